/* include/rv_pipe_defs.svh */
`ifndef RV_PIPE_DEFS_SVH
`define RV_PIPE_DEFS_SVH

// Datapath widths
`define XLEN            32
`define INSTR_BIT       32
`define REG_ADDR_BIT    5
`define NUM_REGS        32

// First fetch address
`define RESET_PC        32'h0000_0000

// funct3 values of the kept ALU ops
`define F3_ADD          3'b000
`define F3_XOR          3'b100
`define F3_OR           3'b110
`define F3_AND          3'b111

// Branch funct3 values
`define F3_BEQ          3'b000
`define F3_BNE          3'b001

`define F7_SUB          7'b0100000

`endif

/* src/rv_pipe_pkg.sv */
`include "rv_pipe_defs.svh"

package rv_pipe_pkg;

// Major opcodes, encoded as the RV32I opcode field
typedef enum logic [6:0] {
    OP_NONE   = 7'b0000000,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
} opcode_e;

typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_PASS_B = 3'd5
} alu_op_e;

// Decoded instruction handed from decode to execute
typedef struct packed {
    logic [`XLEN-1:0]           pc;
    opcode_e                    opcode;
    alu_op_e                    alu_op;
    logic [`REG_ADDR_BIT-1:0]   rd;
    logic [`XLEN-1:0]           operand_a;
    logic [`XLEN-1:0]           operand_b;
    logic [`XLEN-1:0]           rs2_value;
    logic [`XLEN-1:0]           imm;
    logic                       branch_ne;
} uop_t;

endpackage

/* src/pipe_if.sv */
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

// Item moves on a rising edge with valid and ready both high,
// flush drops whatever the producer holds
interface pipe_if;

    logic                   valid;
    logic                   ready;
    logic [`XLEN-1:0]       pc;
    logic [`INSTR_BIT-1:0]  instr;
    logic                   flush;

    modport producer (
        output valid,
        output pc,
        output instr,
        input  ready,
        input  flush
    );

    modport consumer (
        input  valid,
        input  pc,
        input  instr,
        input  flush,
        output ready
    );

endinterface

/* src/fetch_unit.sv */
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module fetch_unit (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // Instruction request
    output logic                    imem_req_valid_o,
    output logic [`XLEN-1:0]        imem_req_addr_o,
    input  logic                    imem_req_ready_i,

    // Instruction response
    input  logic                    imem_rsp_valid_i,
    input  logic [`INSTR_BIT-1:0]   imem_rsp_data_i,
    output logic                    imem_rsp_ready_o,

    input  logic                    redirect_valid_i,
    input  logic [`XLEN-1:0]        redirect_pc_i,

    pipe_if.producer                fd_o
);

logic                   req_valid_r;
logic [`XLEN-1:0]       req_addr_r;
logic                   outstanding_r;
logic                   discard_r;
logic [`XLEN-1:0]       pc_r;
logic                   buf_valid_r;
logic [`XLEN-1:0]       buf_pc_r;
logic [`INSTR_BIT-1:0]  buf_instr_r;

logic                   req_fire_w;
logic                   rsp_fire_w;
logic                   handoff_w;
logic                   issue_w;

assign req_fire_w = req_valid_r && imem_req_ready_i;
assign rsp_fire_w = imem_rsp_valid_i && imem_rsp_ready_o;
assign handoff_w  = fd_o.valid && fd_o.ready;

// Nothing in flight and the buffer is free after this edge
assign issue_w = !req_valid_r && !outstanding_r
              && (!buf_valid_r || handoff_w || fd_o.flush);

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        req_valid_r   <= 1'b0;
        outstanding_r <= 1'b0;
        discard_r     <= 1'b0;
        buf_valid_r   <= 1'b0;
        pc_r          <= `RESET_PC;
    end
    else begin
        if (req_fire_w) begin
            req_valid_r <= 1'b0;
        end
        else if (issue_w) begin
            req_valid_r <= 1'b1;
        end

        if (req_fire_w) begin
            outstanding_r <= 1'b1;
        end
        else if (rsp_fire_w) begin
            outstanding_r <= 1'b0;
        end

        // Response still owed for a squashed path
        if (rsp_fire_w) begin
            discard_r <= 1'b0;
        end
        else if (redirect_valid_i && (req_valid_r || outstanding_r)) begin
            discard_r <= 1'b1;
        end

        if (redirect_valid_i) begin
            pc_r <= redirect_pc_i;
        end
        else if (rsp_fire_w && !discard_r) begin
            pc_r <= req_addr_r + 32'd4;
        end

        if (fd_o.flush) begin
            buf_valid_r <= 1'b0;
        end
        else if (rsp_fire_w && !discard_r) begin
            buf_valid_r <= 1'b1;
        end
        else if (handoff_w) begin
            buf_valid_r <= 1'b0;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (issue_w) begin
        req_addr_r <= redirect_valid_i ? redirect_pc_i : pc_r;
    end
    if (rsp_fire_w && !discard_r) begin
        buf_pc_r    <= req_addr_r;
        buf_instr_r <= imem_rsp_data_i;
    end
end

assign imem_req_valid_o = req_valid_r;
assign imem_req_addr_o  = req_addr_r;
assign imem_rsp_ready_o = !buf_valid_r;

assign fd_o.valid = buf_valid_r;
assign fd_o.pc    = buf_pc_r;
assign fd_o.instr = buf_instr_r;

endmodule

/* src/decode_unit.sv */
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module decode_unit
    import rv_pipe_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,

    pipe_if.consumer                    fd_i,
    input  logic                        redirect_valid_i,

    // Writeback port into the register file
    input  logic                        wb_valid_i,
    input  logic [`REG_ADDR_BIT-1:0]    wb_rd_i,
    input  logic [`XLEN-1:0]            wb_data_i,

    output uop_t                        uop_o,
    output logic                        uop_valid_o
);

logic [`XLEN-1:0]           regs_r [1:`NUM_REGS-1];
uop_t                       uop_r;
logic                       uop_valid_r;

logic [`REG_ADDR_BIT-1:0]   rs1_w;
logic [`REG_ADDR_BIT-1:0]   rs2_w;
logic [`REG_ADDR_BIT-1:0]   rd_w;
logic [2:0]                 funct3_w;
logic [6:0]                 funct7_w;
logic [`XLEN-1:0]           imm_i_w;
logic [`XLEN-1:0]           imm_u_w;
logic [`XLEN-1:0]           imm_b_w;
logic [`XLEN-1:0]           imm_j_w;
logic [`XLEN-1:0]           rs1_val_w;
logic [`XLEN-1:0]           rs2_val_w;
logic                       hazard_w;
logic                       take_w;

uop_t                       uop_cmb;
alu_op_e                    alu_f3_cmb;
logic                       f3_ok_cmb;
logic                       use_rs1_cmb;
logic                       use_rs2_cmb;

assign rs1_w    = fd_i.instr[19:15];
assign rs2_w    = fd_i.instr[24:20];
assign rd_w     = fd_i.instr[11:7];
assign funct3_w = fd_i.instr[14:12];
assign funct7_w = fd_i.instr[31:25];

assign imm_i_w = {{20{fd_i.instr[31]}}, fd_i.instr[31:20]};
assign imm_u_w = {fd_i.instr[31:12], 12'b0};
assign imm_b_w = {{20{fd_i.instr[31]}}, fd_i.instr[7], fd_i.instr[30:25],
                  fd_i.instr[11:8], 1'b0};
assign imm_j_w = {{12{fd_i.instr[31]}}, fd_i.instr[19:12], fd_i.instr[20],
                  fd_i.instr[30:21], 1'b0};

// Register read with write-through from the writeback register
assign rs1_val_w = (rs1_w == '0) ? '0
                 : (wb_valid_i && wb_rd_i == rs1_w) ? wb_data_i : regs_r[rs1_w];
assign rs2_val_w = (rs2_w == '0) ? '0
                 : (wb_valid_i && wb_rd_i == rs2_w) ? wb_data_i : regs_r[rs2_w];

always_comb begin
    f3_ok_cmb  = 1'b1;
    alu_f3_cmb = ALU_ADD;
    case (funct3_w)
        `F3_ADD: alu_f3_cmb = ALU_ADD;
        `F3_XOR: alu_f3_cmb = ALU_XOR;
        `F3_OR:  alu_f3_cmb = ALU_OR;
        `F3_AND: alu_f3_cmb = ALU_AND;
        default: f3_ok_cmb  = 1'b0;
    endcase
end

always_comb begin
    uop_cmb.pc        = fd_i.pc;
    uop_cmb.opcode    = OP_NONE;
    uop_cmb.alu_op    = ALU_ADD;
    uop_cmb.rd        = '0;
    uop_cmb.operand_a = rs1_val_w;
    uop_cmb.operand_b = rs2_val_w;
    uop_cmb.rs2_value = rs2_val_w;
    uop_cmb.imm       = imm_i_w;
    uop_cmb.branch_ne = 1'b0;
    use_rs1_cmb       = 1'b0;
    use_rs2_cmb       = 1'b0;
    case (fd_i.instr[6:0])
        OP_IMM: begin
            if (f3_ok_cmb) begin
                uop_cmb.opcode    = OP_IMM;
                uop_cmb.alu_op    = alu_f3_cmb;
                uop_cmb.rd        = rd_w;
                uop_cmb.operand_b = imm_i_w;
                use_rs1_cmb       = 1'b1;
            end
        end
        OP_REG: begin
            if (f3_ok_cmb && (funct7_w == 7'b0
                    || (funct7_w == `F7_SUB && funct3_w == `F3_ADD))) begin
                uop_cmb.opcode = OP_REG;
                uop_cmb.alu_op = funct7_w[5] ? ALU_SUB : alu_f3_cmb;
                uop_cmb.rd     = rd_w;
                use_rs1_cmb    = 1'b1;
                use_rs2_cmb    = 1'b1;
            end
        end
        OP_LUI: begin
            uop_cmb.opcode    = OP_LUI;
            uop_cmb.alu_op    = ALU_PASS_B;
            uop_cmb.rd        = rd_w;
            uop_cmb.operand_b = imm_u_w;
        end
        OP_BRANCH: begin
            if (funct3_w == `F3_BEQ || funct3_w == `F3_BNE) begin
                uop_cmb.opcode    = OP_BRANCH;
                uop_cmb.imm       = imm_b_w;
                uop_cmb.branch_ne = (funct3_w == `F3_BNE);
                use_rs1_cmb       = 1'b1;
                use_rs2_cmb       = 1'b1;
            end
        end
        OP_JAL: begin
            uop_cmb.opcode = OP_JAL;
            uop_cmb.rd     = rd_w;
            uop_cmb.imm    = imm_j_w;
        end
        default: begin
            uop_cmb.opcode = OP_NONE;
        end
    endcase
end

// Source waits one cycle on the result still in the output register
assign hazard_w = fd_i.valid && uop_valid_r && (uop_r.rd != '0)
               && ((use_rs1_cmb && rs1_w == uop_r.rd)
                || (use_rs2_cmb && rs2_w == uop_r.rd));

assign fd_i.ready = !hazard_w;
assign take_w     = fd_i.valid && fd_i.ready && !fd_i.flush;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        uop_valid_r <= 1'b0;
    end
    else if (redirect_valid_i) begin
        uop_valid_r <= 1'b0;
    end
    else begin
        uop_valid_r <= take_w;
    end
end

always_ff @(posedge clk_i) begin
    if (take_w) begin
        uop_r <= uop_cmb;
    end
    if (wb_valid_i && wb_rd_i != '0) begin
        regs_r[wb_rd_i] <= wb_data_i;
    end
end

assign uop_o       = uop_r;
assign uop_valid_o = uop_valid_r;

endmodule

/* src/execute_unit.sv */
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module execute_unit
    import rv_pipe_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,

    input  uop_t                        uop_i,
    input  logic                        uop_valid_i,

    // Fetch redirect for taken branches and jumps
    output logic                        redirect_valid_o,
    output logic [`XLEN-1:0]            redirect_pc_o,

    output logic                        wb_valid_o,
    output logic [`REG_ADDR_BIT-1:0]    wb_rd_o,
    output logic [`XLEN-1:0]            wb_data_o,
    output logic [`XLEN-1:0]            wb_pc_o
);

logic [`XLEN-1:0]           alu_result_cmb;
logic [`XLEN-1:0]           result_cmb;
logic [`XLEN-1:0]           link_w;
logic                       branch_taken_w;
logic                       jump_w;

logic                       wb_valid_r;
logic [`REG_ADDR_BIT-1:0]   wb_rd_r;
logic [`XLEN-1:0]           wb_data_r;
logic [`XLEN-1:0]           wb_pc_r;

always_comb begin
    case (uop_i.alu_op)
        ALU_ADD:    alu_result_cmb = uop_i.operand_a + uop_i.operand_b;
        ALU_SUB:    alu_result_cmb = uop_i.operand_a - uop_i.operand_b;
        ALU_AND:    alu_result_cmb = uop_i.operand_a & uop_i.operand_b;
        ALU_OR:     alu_result_cmb = uop_i.operand_a | uop_i.operand_b;
        ALU_XOR:    alu_result_cmb = uop_i.operand_a ^ uop_i.operand_b;
        ALU_PASS_B: alu_result_cmb = uop_i.operand_b;
        default:    alu_result_cmb = '0;
    endcase
end

assign link_w = uop_i.pc + 32'd4;

// Branches, jumps and no-ops retire with zero data
always_comb begin
    case (uop_i.opcode)
        OP_IMM, OP_REG, OP_LUI: result_cmb = alu_result_cmb;
        OP_JAL:                 result_cmb = link_w;
        default:                result_cmb = '0;
    endcase
end

// BNE inverts the equality compare
assign branch_taken_w = uop_valid_i && (uop_i.opcode == OP_BRANCH)
                     && ((uop_i.operand_a == uop_i.rs2_value) ^ uop_i.branch_ne);
assign jump_w         = uop_valid_i && (uop_i.opcode == OP_JAL);

assign redirect_valid_o = branch_taken_w || jump_w;
assign redirect_pc_o    = uop_i.pc + uop_i.imm;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        wb_valid_r <= 1'b0;
    end
    else begin
        wb_valid_r <= uop_valid_i;
    end
end

always_ff @(posedge clk_i) begin
    if (uop_valid_i) begin
        wb_rd_r   <= uop_i.rd;
        wb_data_r <= result_cmb;
        wb_pc_r   <= uop_i.pc;
    end
end

assign wb_valid_o = wb_valid_r;
assign wb_rd_o    = wb_rd_r;
assign wb_data_o  = wb_data_r;
assign wb_pc_o    = wb_pc_r;

endmodule

/* src/rv_pipe.sv */
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module rv_pipe
    import rv_pipe_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,

    // Instruction port
    output logic                        imem_req_valid_o,
    output logic [`XLEN-1:0]            imem_req_addr_o,
    input  logic                        imem_req_ready_i,
    input  logic                        imem_rsp_valid_i,
    input  logic [`INSTR_BIT-1:0]       imem_rsp_data_i,
    output logic                        imem_rsp_ready_o,

    // Retire trace
    output logic                        retire_valid_o,
    output logic [`XLEN-1:0]            retire_pc_o,
    output logic [`REG_ADDR_BIT-1:0]    retire_rd_o,
    output logic [`XLEN-1:0]            retire_data_o
);

pipe_if fd_if ();

uop_t                       uop_w;
logic                       uop_valid_w;
logic                       redirect_valid_w;
logic [`XLEN-1:0]           redirect_pc_w;
logic                       wb_valid_w;
logic [`REG_ADDR_BIT-1:0]   wb_rd_w;
logic [`XLEN-1:0]           wb_data_w;
logic [`XLEN-1:0]           wb_pc_w;

// Execute redirect squashes the fetch buffer
assign fd_if.flush = redirect_valid_w;

fetch_unit fetch_i (
    .clk_i              ( clk_i ),
    .rst_i              ( rst_i ),
    .imem_req_valid_o   ( imem_req_valid_o ),
    .imem_req_addr_o    ( imem_req_addr_o ),
    .imem_req_ready_i   ( imem_req_ready_i ),
    .imem_rsp_valid_i   ( imem_rsp_valid_i ),
    .imem_rsp_data_i    ( imem_rsp_data_i ),
    .imem_rsp_ready_o   ( imem_rsp_ready_o ),
    .redirect_valid_i   ( redirect_valid_w ),
    .redirect_pc_i      ( redirect_pc_w ),
    .fd_o               ( fd_if.producer )
);

decode_unit decode_i (
    .clk_i              ( clk_i ),
    .rst_i              ( rst_i ),
    .fd_i               ( fd_if.consumer ),
    .redirect_valid_i   ( redirect_valid_w ),
    .wb_valid_i         ( wb_valid_w ),
    .wb_rd_i            ( wb_rd_w ),
    .wb_data_i          ( wb_data_w ),
    .uop_o              ( uop_w ),
    .uop_valid_o        ( uop_valid_w )
);

execute_unit execute_i (
    .clk_i              ( clk_i ),
    .rst_i              ( rst_i ),
    .uop_i              ( uop_w ),
    .uop_valid_i        ( uop_valid_w ),
    .redirect_valid_o   ( redirect_valid_w ),
    .redirect_pc_o      ( redirect_pc_w ),
    .wb_valid_o         ( wb_valid_w ),
    .wb_rd_o            ( wb_rd_w ),
    .wb_data_o          ( wb_data_w ),
    .wb_pc_o            ( wb_pc_w )
);

assign retire_valid_o = wb_valid_w;
assign retire_pc_o    = wb_pc_w;
assign retire_rd_o    = wb_rd_w;
assign retire_data_o  = wb_data_w;

endmodule

/* verification/rv_pipe_sva.sv */
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module rv_pipe_sva (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                imem_req_valid_o,
    input  logic [`XLEN-1:0]    imem_req_addr_o,
    input  logic                imem_req_ready_i,
    input  logic                imem_rsp_valid_i,
    input  logic                imem_rsp_ready_o,
    input  logic                retire_valid_o,
    input  logic [`XLEN-1:0]    retire_pc_o
);

int     fail_count = 0;
logic   first_req_r;
logic   outstanding_r;

// Tracks the first request and the one request in flight
always_ff @(posedge clk_i) begin
    if (rst_i) begin
        first_req_r   <= 1'b1;
        outstanding_r <= 1'b0;
    end
    else if (imem_req_valid_o && imem_req_ready_i) begin
        first_req_r   <= 1'b0;
        outstanding_r <= 1'b1;
    end
    else if (imem_rsp_valid_i && imem_rsp_ready_o) begin
        outstanding_r <= 1'b0;
    end
end

reset_quiet_a: assert property (@(posedge clk_i)
    rst_i |=> !imem_req_valid_o && !retire_valid_o)
    else begin
        $error("request or retire active during reset");
        fail_count++;
    end

first_addr_a: assert property (@(posedge clk_i) disable iff (rst_i)
    imem_req_valid_o && imem_req_ready_i && first_req_r |-> imem_req_addr_o == `RESET_PC)
    else begin
        $error("first request not at the reset address");
        fail_count++;
    end

req_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    imem_req_valid_o && !imem_req_ready_i |=> imem_req_valid_o && $stable(imem_req_addr_o))
    else begin
        $error("request dropped or changed while not accepted");
        fail_count++;
    end

single_outstanding_a: assert property (@(posedge clk_i) disable iff (rst_i)
    outstanding_r |-> !imem_req_valid_o)
    else begin
        $error("new request issued while one is outstanding");
        fail_count++;
    end

retire_align_a: assert property (@(posedge clk_i) disable iff (rst_i)
    retire_valid_o |-> retire_pc_o[1:0] == 2'b00)
    else begin
        $error("retired pc not word aligned");
        fail_count++;
    end

endmodule

/* verification/rv_pipe_tb.sv */
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module rv_pipe_tb;

localparam int          CLK_PERIOD = 40;
localparam int          PROG_LEN   = 24;
// Instructions times cycles each, doubled for margin
localparam int          TIMEOUT_NS = PROG_LEN * 8 * CLK_PERIOD * 2;
localparam logic [31:0] SEED       = 32'h6a47;

logic                       clk_i;
logic                       rst_i;
logic                       imem_req_valid_o;
logic [`XLEN-1:0]           imem_req_addr_o;
logic                       imem_req_ready_i;
logic                       imem_rsp_valid_i;
logic [`INSTR_BIT-1:0]      imem_rsp_data_i;
logic                       imem_rsp_ready_o;
logic                       retire_valid_o;
logic [`XLEN-1:0]           retire_pc_o;
logic [`REG_ADDR_BIT-1:0]   retire_rd_o;
logic [`XLEN-1:0]           retire_data_o;

logic [`INSTR_BIT-1:0]      prog_q [$];
logic [`XLEN-1:0]           exp_pc_q [$];
logic [`REG_ADDR_BIT-1:0]   exp_rd_q [$];
logic [`XLEN-1:0]           exp_data_q [$];
int                         exp_idx;
int                         retire_errors;

rv_pipe rv_pipe_i (
    .clk_i              ( clk_i ),
    .rst_i              ( rst_i ),
    .imem_req_valid_o   ( imem_req_valid_o ),
    .imem_req_addr_o    ( imem_req_addr_o ),
    .imem_req_ready_i   ( imem_req_ready_i ),
    .imem_rsp_valid_i   ( imem_rsp_valid_i ),
    .imem_rsp_data_i    ( imem_rsp_data_i ),
    .imem_rsp_ready_o   ( imem_rsp_ready_o ),
    .retire_valid_o     ( retire_valid_o ),
    .retire_pc_o        ( retire_pc_o ),
    .retire_rd_o        ( retire_rd_o ),
    .retire_data_o      ( retire_data_o )
);

bind rv_pipe rv_pipe_sva sva_chk_i (
    .clk_i              ( clk_i ),
    .rst_i              ( rst_i ),
    .imem_req_valid_o   ( imem_req_valid_o ),
    .imem_req_addr_o    ( imem_req_addr_o ),
    .imem_req_ready_i   ( imem_req_ready_i ),
    .imem_rsp_valid_i   ( imem_rsp_valid_i ),
    .imem_rsp_ready_o   ( imem_rsp_ready_o ),
    .retire_valid_o     ( retire_valid_o ),
    .retire_pc_o        ( retire_pc_o )
);

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// Unmapped words read back their own address, low bits 00 never form a kept opcode
function automatic logic [`INSTR_BIT-1:0] fetch_word(input logic [`XLEN-1:0] addr);
    int idx;
    idx = int'(addr[31:2]);
    if (idx < prog_q.size()) begin
        return prog_q[idx];
    end
    return addr;
endfunction

task automatic load_program();
    prog_q.push_back(i_type(12'h123, 5'd0, 3'b000, 5'd1));      // addi x1, x0, 0x123
    prog_q.push_back(i_type(12'hffd, 5'd1, 3'b000, 5'd2));      // addi x2, x1, -3
    prog_q.push_back(i_type(12'h0ff, 5'd2, 3'b100, 5'd3));      // xori x3, x2, 0xff
    prog_q.push_back(i_type(12'h400, 5'd3, 3'b110, 5'd4));      // ori  x4, x3, 0x400
    prog_q.push_back(i_type(12'h0f0, 5'd4, 3'b111, 5'd5));      // andi x5, x4, 0xf0
    prog_q.push_back(lui_word(20'habcde, 5'd6));                // lui  x6, 0xabcde
    prog_q.push_back(r_type(7'h00, 5'd1, 5'd6, 3'b000, 5'd7));  // add  x7, x6, x1
    prog_q.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd8));  // sub  x8, x1, x2
    prog_q.push_back(r_type(7'h00, 5'd6, 5'd7, 3'b100, 5'd9));  // xor  x9, x7, x6
    prog_q.push_back(r_type(7'h00, 5'd8, 5'd5, 3'b110, 5'd10)); // or   x10, x5, x8
    prog_q.push_back(r_type(7'h00, 5'd3, 5'd7, 3'b111, 5'd11)); // and  x11, x7, x3
    prog_q.push_back(i_type(12'h005, 5'd0, 3'b000, 5'd0));      // addi x0, x0, 5
    prog_q.push_back(r_type(7'h00, 5'd8, 5'd0, 3'b000, 5'd12)); // add  x12, x0, x8
    prog_q.push_back(b_type(13'd12, 5'd9, 5'd1, 3'b000));       // beq  x1, x9, +12
    prog_q.push_back(i_type(12'h001, 5'd0, 3'b000, 5'd13));
    prog_q.push_back(i_type(12'h002, 5'd0, 3'b000, 5'd13));
    prog_q.push_back(b_type(13'd8, 5'd9, 5'd1, 3'b001));        // bne  x1, x9, +8
    prog_q.push_back(b_type(13'd8, 5'd2, 5'd1, 3'b001));        // bne  x1, x2, +8
    prog_q.push_back(i_type(12'h003, 5'd0, 3'b000, 5'd13));
    prog_q.push_back(j_type(21'd8, 5'd14));                     // jal  x14, +8
    prog_q.push_back(i_type(12'h004, 5'd0, 3'b000, 5'd13));
    prog_q.push_back(r_type(7'h00, 5'd12, 5'd14, 3'b000, 5'd15));
    prog_q.push_back(i_type(12'h002, 5'd1, 3'b001, 5'd16));     // slli, not kept
    prog_q.push_back(j_type(21'd0, 5'd0));                      // jal  x0, 0
endtask

task automatic expect_retire(input logic [31:0] pc, input logic [4:0] rd,
                             input logic [31:0] data);
    exp_pc_q.push_back(pc);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
endtask

task automatic load_expected();
    expect_retire(32'h00, 5'd1, 32'h0000_0123);
    expect_retire(32'h04, 5'd2, 32'h0000_0120);
    expect_retire(32'h08, 5'd3, 32'h0000_01df);
    expect_retire(32'h0c, 5'd4, 32'h0000_05df);
    expect_retire(32'h10, 5'd5, 32'h0000_00d0);
    expect_retire(32'h14, 5'd6, 32'habcd_e000);
    expect_retire(32'h18, 5'd7, 32'habcd_e123);
    expect_retire(32'h1c, 5'd8, 32'h0000_0003);
    expect_retire(32'h20, 5'd9, 32'h0000_0123);
    expect_retire(32'h24, 5'd10, 32'h0000_00d3);
    expect_retire(32'h28, 5'd11, 32'h0000_0103);
    expect_retire(32'h2c, 5'd0, 32'h0000_0005);
    expect_retire(32'h30, 5'd12, 32'h0000_0003);
    // Branches retire with no data, squashed slots never show up
    expect_retire(32'h34, 5'd0, 32'h0);
    expect_retire(32'h40, 5'd0, 32'h0);
    expect_retire(32'h44, 5'd0, 32'h0);
    expect_retire(32'h4c, 5'd14, 32'h0000_0050);
    expect_retire(32'h54, 5'd15, 32'h0000_0053);
    expect_retire(32'h58, 5'd0, 32'h0);
    expect_retire(32'h5c, 5'd0, 32'h0000_0060);
    expect_retire(32'h5c, 5'd0, 32'h0000_0060);
endtask

initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
end

// Instruction memory with random latency and request back-pressure
initial begin
    logic           pend;
    logic [31:0]    pend_addr;
    logic [1:0]     lat;
    logic [31:0]    rng;
    pend      = 1'b0;
    pend_addr = '0;
    lat       = '0;
    rng       = SEED;
    imem_req_ready_i <= 1'b0;
    imem_rsp_valid_i <= 1'b0;
    imem_rsp_data_i  <= '0;
    forever begin
        @(posedge clk_i);
        rng = xorshift32(rng);
        if (rst_i) begin
            pend = 1'b0;
            imem_req_ready_i <= 1'b0;
            imem_rsp_valid_i <= 1'b0;
        end
        else begin
            if (imem_rsp_valid_i && imem_rsp_ready_o) begin
                imem_rsp_valid_i <= 1'b0;
            end
            if (pend) begin
                if (lat == 2'd0) begin
                    imem_rsp_valid_i <= 1'b1;
                    imem_rsp_data_i  <= fetch_word(pend_addr);
                    pend = 1'b0;
                end
                else begin
                    lat = lat - 2'd1;
                end
            end
            if (imem_req_valid_o && imem_req_ready_i) begin
                pend      = 1'b1;
                pend_addr = imem_req_addr_o;
                lat       = rng[5:4];
            end
            imem_req_ready_i <= (rng[1:0] != 2'b00);
        end
    end
end

always @(posedge clk_i) begin
    if (rst_i) begin
        exp_idx       = 0;
        retire_errors = 0;
    end
    else if (retire_valid_o && exp_idx < exp_pc_q.size()) begin
        assert (retire_pc_o == exp_pc_q[exp_idx]) else begin
            retire_errors++;
            $display("Error: %0t retire_pc_o expected %h actual %h",
                     $time, exp_pc_q[exp_idx], retire_pc_o);
        end
        assert (retire_rd_o == exp_rd_q[exp_idx]) else begin
            retire_errors++;
            $display("Error: %0t retire_rd_o expected %0d actual %0d",
                     $time, exp_rd_q[exp_idx], retire_rd_o);
        end
        assert (retire_data_o == exp_data_q[exp_idx]) else begin
            retire_errors++;
            $display("Error: %0t retire_data_o expected %h actual %h",
                     $time, exp_data_q[exp_idx], retire_data_o);
        end
        exp_idx++;
    end
end

initial begin
    #(TIMEOUT_NS);
    $display("Timeout: only %0d of %0d instructions retired within %0d ns",
             exp_idx, exp_pc_q.size(), TIMEOUT_NS);
    $display("Done: errors found");
    $finish;
end

initial begin
    rst_i <= 1'b1;
    load_program();
    load_expected();
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    wait (exp_idx == exp_pc_q.size());
    @(posedge clk_i);
    $display("Retired %0d of %0d, retire errors %0d, assertion errors %0d",
             exp_idx, exp_pc_q.size(), retire_errors, rv_pipe_i.sva_chk_i.fail_count);
    if (retire_errors == 0 && rv_pipe_i.sva_chk_i.fail_count == 0) begin
        $display("Done: no errors");
    end
    else begin
        $display("Done: errors found");
    end
    $finish;
end

endmodule

/* rv_pipe.f */
+incdir+include
src/rv_pipe_pkg.sv
src/pipe_if.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/rv_pipe.sv
verification/rv_pipe_sva.sv
verification/rv_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rv_pipe_tb -f rv_pipe.f -o rv_pipe_sim \
    && ./obj_dir/rv_pipe_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
